//--- rtl/icache_data_stage.sv
// Data stage of the lookup pipeline: line memory port mux, response
// metadata register and a fall-through buffer for the read line

`timescale 1ns/1ps

module icache_data_stage (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  icache_pkg::tag_result_t  tag_i,
    input  logic                     tag_valid_i,
    output logic                     tag_ready_o,
    input  icache_pkg::refill_t      refill_i,
    input  logic                     refill_valid_i,
    input  logic                     refill_ready_i,
    output logic                     data_write_o,
    output icache_pkg::lookup_rsp_t  rsp_o,
    output logic                     rsp_valid_o,
    input  logic                     rsp_ready_i
);

    import icache_pkg::*;

    logic                             tag_hs;
    logic [SET_ALIGN+COUNT_ALIGN-1:0] data_addr;
    logic                             data_en;
    line_t                            data_rdata;

    tag_result_t                      meta_q;
    logic                             valid_q;
    logic                             read_q;
    line_t                            line_q;
    line_t                            line;

    // The refill ready comes from the tag stage, which owns the decision
    assign data_write_o = refill_valid_i && refill_ready_i;
    assign tag_ready_o  = (!valid_q || rsp_ready_i) && !data_write_o;
    assign tag_hs       = tag_valid_i && tag_ready_o;

    // --------------------------------------------------
    // Line memory port mux
    // --------------------------------------------------
    always_comb begin
        data_addr = {tag_i.cset, tag_i.addr[LINE_ALIGN +: COUNT_ALIGN]};
        // Misses pass through without touching the memory
        data_en   = tag_hs && tag_i.hit;
        if (data_write_o) begin
            data_addr = {refill_i.cset, refill_i.index};
            data_en   = 1'b1;
        end
    end

    icache_sram #(
        .word_t    (line_t),
        .NUM_WORDS (SET_COUNT * LINE_COUNT)
    ) i_data (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .req_i   (data_en),
        .we_i    (data_write_o),
        .addr_i  (data_addr),
        .wdata_i (refill_i.line),
        .rdata_o (data_rdata)
    );

    // --------------------------------------------------
    // Response registers
    // --------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (tag_hs) begin
            meta_q <= tag_i;
        end
        // Keep the line only if the consumer did not take it straight away
        if (read_q && !rsp_ready_i) begin
            line_q <= data_rdata;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= 1'b0;
            read_q  <= 1'b0;
        end else begin
            read_q <= tag_hs && tag_i.hit;
            if (tag_hs) begin
                valid_q <= 1'b1;
            end else if (rsp_ready_i) begin
                valid_q <= 1'b0;
            end
        end
    end

    assign line        = read_q ? data_rdata : line_q;
    assign rsp_valid_o = valid_q;
    assign rsp_o       = '{addr: meta_q.addr, id: meta_q.id, cset: meta_q.cset,
                           hit: meta_q.hit, error: meta_q.error, line: line};

endmodule

//--- rtl/icache_init_ctrl.sv
// Init sequencer that walks all tag indices after reset and after a flush

`timescale 1ns/1ps

module icache_init_ctrl (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  logic                flush_valid_i,
    output logic                init_busy_o,
    output icache_pkg::index_t  init_index_o
);

    import icache_pkg::*;

    // One bit wider than the index so that LINE_COUNT itself marks "done"
    logic [COUNT_ALIGN:0] count_q;

    assign init_busy_o  = count_q != (COUNT_ALIGN + 1)'(LINE_COUNT);
    assign init_index_o = count_q[COUNT_ALIGN-1:0];

    // A flush only restarts the walk once the previous one has finished
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            count_q <= '0;
        end else if (init_busy_o) begin
            count_q <= count_q + 1'b1;
        end else if (flush_valid_i) begin
            count_q <= '0;
        end
    end

endmodule

//--- rtl/icache_lookup.sv
// Top level of the two-stage instruction cache lookup pipeline
// Connects the init sequencer, the tag stage and the data stage

`timescale 1ns/1ps

module icache_lookup (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic                     flush_valid_i,
    input  icache_pkg::lookup_req_t  in_req_i,
    input  logic                     in_valid_i,
    output logic                     in_ready_o,
    output icache_pkg::lookup_rsp_t  out_rsp_o,
    output logic                     out_valid_o,
    input  logic                     out_ready_i,
    input  icache_pkg::refill_t      write_i,
    input  logic                     write_valid_i,
    output logic                     write_ready_o
);

    import icache_pkg::*;

    logic        init_busy;
    index_t      init_index;
    tag_result_t tag_result;
    logic        tag_valid;
    logic        tag_ready;
    logic        data_write;

    icache_init_ctrl i_init (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .flush_valid_i (flush_valid_i),
        .init_busy_o   (init_busy),
        .init_index_o  (init_index)
    );

    icache_tag_stage i_tag_stage (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .init_busy_i    (init_busy),
        .init_index_i   (init_index),
        .req_i          (in_req_i),
        .req_valid_i    (in_valid_i),
        .req_ready_o    (in_ready_o),
        .refill_i       (write_i),
        .refill_valid_i (write_valid_i),
        .refill_ready_o (write_ready_o),
        .data_write_i   (data_write),
        .result_o       (tag_result),
        .result_valid_o (tag_valid),
        .result_ready_i (tag_ready)
    );

    icache_data_stage i_data_stage (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .tag_i          (tag_result),
        .tag_valid_i    (tag_valid),
        .tag_ready_o    (tag_ready),
        .refill_i       (write_i),
        .refill_valid_i (write_valid_i),
        .refill_ready_i (write_ready_o),
        .data_write_o   (data_write),
        .rsp_o          (out_rsp_o),
        .rsp_valid_o    (out_valid_o),
        .rsp_ready_i    (out_ready_i)
    );

endmodule

//--- rtl/icache_pkg.sv
// Geometry constants of the instruction cache lookup pipeline
// Packed types shared by the tag stage, the data stage and the top level

package icache_pkg;

    // --------------------------------------------------
    // Geometry
    // --------------------------------------------------
    localparam int unsigned FETCH_AW    = 32;
    localparam int unsigned ID_W        = 4;
    localparam int unsigned LINE_WIDTH  = 64;
    localparam int unsigned LINE_ALIGN  = 3;
    localparam int unsigned LINE_COUNT  = 16;
    localparam int unsigned COUNT_ALIGN = 4;
    localparam int unsigned SET_COUNT   = 2;
    localparam int unsigned SET_ALIGN   = 1;
    // Address bits left above the byte offset and the index
    localparam int unsigned TAG_WIDTH   = FETCH_AW - LINE_ALIGN - COUNT_ALIGN;

    // --------------------------------------------------
    // Types
    // --------------------------------------------------
    typedef logic [FETCH_AW-1:0]    addr_t;
    typedef logic [ID_W-1:0]        id_t;
    typedef logic [SET_ALIGN-1:0]   set_t;
    typedef logic [COUNT_ALIGN-1:0] index_t;
    typedef logic [TAG_WIDTH-1:0]   tag_t;
    typedef logic [LINE_WIDTH-1:0]  line_t;

    // One word of a tag memory
    typedef struct packed {
        logic valid;
        logic error;
        tag_t tag;
    } tag_entry_t;

    typedef struct packed {
        addr_t addr;
        id_t   id;
    } lookup_req_t;

    // Handed from the tag stage to the data stage
    typedef struct packed {
        addr_t addr;
        id_t   id;
        set_t  cset;
        logic  hit;
        logic  error;
    } tag_result_t;

    typedef struct packed {
        addr_t addr;
        id_t   id;
        set_t  cset;
        logic  hit;
        logic  error;
        line_t line;
    } lookup_rsp_t;

    typedef struct packed {
        index_t index;
        set_t   cset;
        tag_t   tag;
        line_t  line;
        logic   error;
    } refill_t;

endpackage

//--- rtl/icache_sram.sv
// Single-port synchronous memory with one cycle of read latency
// The stored word is a type parameter, so tags and lines share this model

`timescale 1ns/1ps

module icache_sram #(
    parameter type         word_t    = logic,
    parameter int unsigned NUM_WORDS = 16
) (
    input  logic                         clk_i,
    input  logic                         rst_ni,
    input  logic                         req_i,
    input  logic                         we_i,
    input  logic [$clog2(NUM_WORDS)-1:0] addr_i,
    input  word_t                        wdata_i,
    output word_t                        rdata_o
);

    word_t mem_q [NUM_WORDS];

    // Array contents are defined only by writes
    always_ff @(posedge clk_i) begin
        if (req_i && we_i) begin
            mem_q[addr_i] <= wdata_i;
        end
    end

    // Read port, the output holds between reads and during writes
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rdata_o <= '0;
        end else if (req_i && !we_i) begin
            rdata_o <= mem_q[addr_i];
        end
    end

endmodule

//--- rtl/icache_tag_stage.sv
// Tag stage of the lookup pipeline: tag memory port mux, per-set compare,
// request register and a fall-through buffer for the tag result

`timescale 1ns/1ps

module icache_tag_stage (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic                     init_busy_i,
    input  icache_pkg::index_t       init_index_i,
    input  icache_pkg::lookup_req_t  req_i,
    input  logic                     req_valid_i,
    output logic                     req_ready_o,
    input  icache_pkg::refill_t      refill_i,
    input  logic                     refill_valid_i,
    output logic                     refill_ready_o,
    input  logic                     data_write_i,
    output icache_pkg::tag_result_t  result_o,
    output logic                     result_valid_o,
    input  logic                     result_ready_i
);

    import icache_pkg::*;

    // Set, hit and error, the part of a result that comes from the compare
    typedef struct packed {
        set_t cset;
        logic hit;
        logic error;
    } hit_info_t;

    logic                 req_hs;
    index_t               tag_addr;
    logic [SET_COUNT-1:0] tag_en;
    logic                 tag_we;
    tag_entry_t           tag_wdata;
    tag_entry_t           tag_rdata [SET_COUNT];

    lookup_req_t          req_q;
    logic                 read_q;
    logic                 valid_q;
    logic [SET_COUNT-1:0] line_hit;
    hit_info_t            fresh;
    hit_info_t            cur;
    hit_info_t            buf_d;
    hit_info_t            buf_q;
    index_t               cur_index;

    // Refills are taken whenever the init walk is not running
    assign refill_ready_o = !init_busy_i;
    assign req_ready_o    = !init_busy_i && !refill_valid_i && (!valid_q || result_ready_i);
    assign req_hs         = req_valid_i && req_ready_o;

    // --------------------------------------------------
    // Tag memory port mux
    // --------------------------------------------------
    always_comb begin
        tag_addr  = req_i.addr[LINE_ALIGN +: COUNT_ALIGN];
        tag_en    = '0;
        tag_we    = 1'b0;
        tag_wdata = '{valid: 1'b1, error: refill_i.error, tag: refill_i.tag};
        if (init_busy_i) begin
            tag_addr  = init_index_i;
            tag_en    = '1;
            tag_we    = 1'b1;
            tag_wdata = '0;
        end else if (refill_valid_i) begin
            tag_addr               = refill_i.index;
            tag_en[refill_i.cset]  = 1'b1;
            tag_we                 = 1'b1;
        end else if (req_hs) begin
            tag_en = '1;
        end
    end

    for (genvar s = 0; s < SET_COUNT; s++) begin : g_set
        icache_sram #(
            .word_t    (tag_entry_t),
            .NUM_WORDS (LINE_COUNT)
        ) i_tag (
            .clk_i   (clk_i),
            .rst_ni  (rst_ni),
            .req_i   (tag_en[s]),
            .we_i    (tag_we),
            .addr_i  (tag_addr),
            .wdata_i (tag_wdata),
            .rdata_o (tag_rdata[s])
        );
    end

    // --------------------------------------------------
    // Compare and set selection
    // --------------------------------------------------
    always_comb begin
        logic [SET_COUNT-1:0] err;
        fresh = '0;
        for (int s = 0; s < SET_COUNT; s++) begin
            line_hit[s] = tag_rdata[s].valid &&
                          tag_rdata[s].tag == req_q.addr[FETCH_AW-1 -: TAG_WIDTH];
            err[s]      = tag_rdata[s].error && line_hit[s];
        end
        // Walk downwards so the lowest hitting set is the one left standing
        for (int s = SET_COUNT - 1; s >= 0; s--) begin
            if (line_hit[s]) begin
                fresh.cset = set_t'(s);
            end
        end
        fresh.hit   = |line_hit;
        fresh.error = |err;
    end

    // --------------------------------------------------
    // Request register and result buffer
    // --------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (req_hs) begin
            req_q <= req_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            read_q  <= 1'b0;
            valid_q <= 1'b0;
        end else begin
            read_q <= req_hs;
            if (req_hs) begin
                valid_q <= 1'b1;
            end else if (result_ready_i) begin
                valid_q <= 1'b0;
            end
        end
    end

    // Memory output right after a read, otherwise the buffered copy
    assign cur       = read_q ? fresh : buf_q;
    assign cur_index = req_q.addr[LINE_ALIGN +: COUNT_ALIGN];

    always_comb begin
        buf_d = buf_q;
        if (read_q && !result_ready_i) begin
            buf_d = fresh;
        end
        // A refill into the line this result points at makes the hit stale
        if (data_write_i && {cur.cset, cur_index} == {refill_i.cset, refill_i.index}) begin
            buf_d.hit = 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        buf_q <= buf_d;
    end

    assign result_valid_o = valid_q;
    assign result_o       = '{addr: req_q.addr, id: req_q.id, cset: cur.cset,
                              hit: cur.hit, error: cur.error};

endmodule

//--- run.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_icache_lookup -f src.f -o sim_icache
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_icache > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q '\*\*\* PASSED \*\*\*' sim.log; then
    exit 0
fi
echo "Pass message not found in sim.log"
exit 1

//--- sim/icache_lookup_asserts.sv
// Concurrent checks on the handshakes of the lookup pipeline top level

`timescale 1ns/1ps

module icache_lookup_asserts (
    input logic                    clk_i,
    input logic                    rst_ni,
    input logic                    in_valid_i,
    input logic                    in_ready_o,
    input logic                    write_valid_i,
    input logic                    write_ready_o,
    input logic                    out_valid_o,
    input logic                    out_ready_i,
    input icache_pkg::lookup_rsp_t out_rsp_o
);

    import icache_pkg::*;

    // Counts cycles since reset release and saturates past the init window
    logic [5:0] cyc_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            cyc_q <= '0;
        end else if (cyc_q != '1) begin
            cyc_q <= cyc_q + 1'b1;
        end
    end

    // The line is only defined for hits
    rsp_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
        out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_rsp_o.addr)
        && $stable(out_rsp_o.id) && $stable(out_rsp_o.cset) && $stable(out_rsp_o.hit)
        && $stable(out_rsp_o.error) && (!out_rsp_o.hit || $stable(out_rsp_o.line)))
        else $error("response changed while stalled");

    init_closed: assert property (@(posedge clk_i) disable iff (!rst_ni)
        cyc_q < LINE_COUNT |-> !in_ready_o && !write_ready_o)
        else $error("ready raised during the init walk");

    no_dual_xfer: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(in_valid_i && in_ready_o && write_valid_i && write_ready_o))
        else $error("lookup and refill transferred together");

endmodule

bind icache_lookup icache_lookup_asserts i_asserts (.*);

//--- sim/tb_icache_lookup.sv
// Testbench for the instruction cache lookup pipeline
// Stimulus table, reference model, compare tasks and watchdog

`timescale 1ns/1ps

module tb_icache_lookup;

    import icache_pkg::*;

    typedef enum logic [1:0] {OP_LOOKUP, OP_REFILL, OP_FLUSH} op_e;
    typedef struct {
        op_e   op;
        addr_t addr;
        set_t  cset;
        line_t line;
        logic  err;
        logic  bp;
    } row_t;
    typedef struct {
        lookup_rsp_t rsp;
        logic        timed;
        int unsigned acc;
    } exp_t;

    localparam int unsigned NUM_ROWS = 56;

    logic clk_i = 1'b0;
    logic rst_ni, flush_valid_i, in_valid_i, in_ready_o, out_valid_o, out_ready_i;
    logic write_valid_i, write_ready_o;
    lookup_req_t in_req_i;
    lookup_rsp_t out_rsp_o;
    refill_t     write_i;

    row_t        rows [NUM_ROWS];
    exp_t        exp_q [$];
    tag_entry_t  ref_tag [SET_COUNT][LINE_COUNT];
    line_t       ref_line [SET_COUNT][LINE_COUNT];
    integer      seed = 32'hcfbb_6ae4;
    logic        bp_on = 1'b0;
    int unsigned cycle_cnt = 0;

    icache_lookup i_dut (.*);

    always #50 clk_i = ~clk_i;
    always @(posedge clk_i) cycle_cnt++;

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_rsp(input lookup_rsp_t got, input lookup_rsp_t exp);
        if (got.addr !== exp.addr || got.id !== exp.id || got.hit !== exp.hit
            || got.error !== exp.error
            || (exp.hit && (got.cset !== exp.cset || got.line !== exp.line))) begin
            fail_now($sformatf("CHECK FAILED at %0t: rsp %h, expected %h", $time, got, exp));
        end
    endtask

    task automatic check_ready(input logic in_rdy, input logic wr_rdy,
                               input logic exp_in, input logic exp_wr);
        if (in_rdy !== exp_in || wr_rdy !== exp_wr) begin
            fail_now($sformatf("CHECK FAILED at %0t: ready %b/%b, expected %b/%b",
                               $time, in_rdy, wr_rdy, exp_in, exp_wr));
        end
    endtask

    function automatic row_t make_row(op_e op, tag_t t, index_t i, set_t s, line_t l,
                                      logic e, logic bp);
        make_row = '{op: op, addr: addr_t'({t, i}) << LINE_ALIGN, cset: s, line: l,
                     err: e, bp: bp};
    endfunction

    // Ready stays low for exactly LINE_COUNT falling edges of the init walk
    task automatic check_init();
        for (int k = 0; k < LINE_COUNT; k++) begin
            #2 check_ready(in_ready_o, write_ready_o, 1'b0, 1'b0);
            @(negedge clk_i);
        end
        #2 check_ready(in_ready_o, write_ready_o, 1'b1, 1'b1);
        @(negedge clk_i);
        foreach (ref_tag[s, i]) ref_tag[s][i] = '0;
    endtask

    task automatic drain();
        wait (exp_q.size() == 0);
        @(negedge clk_i);
    endtask

    // Holds the driven request until it is taken, then queues its expected response
    task automatic await_lookup(input logic timed);
        exp_t   e;
        index_t idx;
        logic   done;
        idx = in_req_i.addr[LINE_ALIGN +: COUNT_ALIGN];
        e = '{rsp: '0, timed: timed, acc: 0};
        e.rsp.addr = in_req_i.addr;
        e.rsp.id   = in_req_i.id;
        done = 1'b0;
        while (!done) begin
            #2;
            if (in_ready_o) begin
                // The lowest hitting set supplies the line and every hitting set adds its error
                for (int s = SET_COUNT - 1; s >= 0; s--) begin
                    if (ref_tag[s][idx].valid &&
                        ref_tag[s][idx].tag == in_req_i.addr[FETCH_AW-1 -: TAG_WIDTH]) begin
                        e.rsp.hit   = 1'b1;
                        e.rsp.cset  = set_t'(s);
                        e.rsp.error |= ref_tag[s][idx].error;
                        e.rsp.line  = ref_line[s][idx];
                    end
                end
                e.acc = cycle_cnt + 1;
                exp_q.push_back(e);
                done = 1'b1;
            end
            @(negedge clk_i);
        end
        in_valid_i = 1'b0;
    endtask

    task automatic do_lookup(input row_t r);
        in_req_i   = '{addr: r.addr, id: id_t'($random(seed))};
        in_valid_i = 1'b1;
        await_lookup(!r.bp);
    endtask

    task automatic do_refill(input row_t r);
        index_t idx;
        idx = r.addr[LINE_ALIGN +: COUNT_ALIGN];
        write_i = '{index: idx, cset: r.cset, tag: r.addr[FETCH_AW-1 -: TAG_WIDTH],
                    line: r.line, error: r.err};
        write_valid_i = 1'b1;
        // A lookup of the same line is offered alongside and has to wait for the refill
        in_req_i   = '{addr: r.addr, id: id_t'($random(seed))};
        in_valid_i = 1'b1;
        #2;
        while (!write_ready_o) begin
            @(negedge clk_i);
            #2;
        end
        check_ready(in_ready_o, write_ready_o, 1'b0, 1'b1);
        ref_tag[r.cset][idx]  = '{valid: 1'b1, error: r.err, tag: write_i.tag};
        ref_line[r.cset][idx] = r.line;
        @(negedge clk_i);
        write_valid_i = 1'b0;
        await_lookup(1'b0);
    endtask

    // Drives the response ready and checks each response that transfers at the next rising edge
    always @(negedge clk_i) begin
        exp_t e;
        out_ready_i = bp_on ? 1'($random(seed)) : 1'b1;
        #1;
        if (rst_ni && out_valid_o && out_ready_i) begin
            if (exp_q.size() == 0) fail_now("Response arrived with no lookup pending");
            e = exp_q.pop_front();
            check_rsp(out_rsp_o, e.rsp);
            if (e.timed && cycle_cnt + 1 - e.acc != 2) begin
                fail_now($sformatf("CHECK FAILED at %0t: latency %0d", $time,
                                   cycle_cnt + 1 - e.acc));
            end
        end
    end

    initial begin
        repeat (NUM_ROWS * 40 + 200) @(posedge clk_i);
        fail_now("Timeout: the pipeline stopped making progress");
    end

    initial begin
        rows[0]  = make_row(OP_LOOKUP, 25'h1234, 4'd5, 1'b0, '0, 1'b0, 1'b0);
        rows[1]  = make_row(OP_LOOKUP, 25'h0, 4'd0, 1'b0, '0, 1'b0, 1'b0);
        rows[2]  = make_row(OP_REFILL, 25'h1234, 4'd5, 1'b1, 64'h1111_2222_3333_4444, 1'b0, 1'b0);
        rows[3]  = make_row(OP_LOOKUP, 25'h1234, 4'd5, 1'b0, '0, 1'b0, 1'b0);
        rows[4]  = make_row(OP_REFILL, 25'h100, 4'd7, 1'b0, 64'hA5A5_0000_FFFF_0101, 1'b0, 1'b0);
        rows[5]  = make_row(OP_REFILL, 25'h200, 4'd7, 1'b1, 64'h0F0F_1234_5678_9ABC, 1'b0, 1'b0);
        rows[6]  = make_row(OP_LOOKUP, 25'h100, 4'd7, 1'b0, '0, 1'b0, 1'b0);
        rows[7]  = make_row(OP_LOOKUP, 25'h200, 4'd7, 1'b0, '0, 1'b0, 1'b0);
        rows[8]  = make_row(OP_LOOKUP, 25'h300, 4'd7, 1'b0, '0, 1'b0, 1'b0);
        rows[9]  = make_row(OP_REFILL, 25'h55, 4'd9, 1'b0, 64'hDEAD_BEEF_CAFE_F00D, 1'b1, 1'b0);
        rows[10] = make_row(OP_LOOKUP, 25'h55, 4'd9, 1'b0, '0, 1'b0, 1'b0);
        rows[11] = make_row(OP_FLUSH, '0, '0, 1'b0, '0, 1'b0, 1'b0);
        rows[12] = make_row(OP_LOOKUP, 25'h1234, 4'd5, 1'b0, '0, 1'b0, 1'b0);
        rows[13] = make_row(OP_LOOKUP, 25'h100, 4'd7, 1'b0, '0, 1'b0, 1'b0);
        rows[14] = make_row(OP_LOOKUP, 25'h55, 4'd9, 1'b0, '0, 1'b0, 1'b0);
        rows[15] = make_row(OP_LOOKUP, 25'h200, 4'd7, 1'b0, '0, 1'b0, 1'b1);
        // Mixed stream over a few tags and indices so that hits are common
        for (int n = 16; n < NUM_ROWS; n++) begin
            rows[n] = make_row(($random(seed) & 3) == 0 ? OP_REFILL : OP_LOOKUP,
                               tag_t'(25'h10 + ($random(seed) & 1)),
                               index_t'($random(seed) & 3), set_t'($random(seed)),
                               {$random(seed), $random(seed)},
                               ($random(seed) & 7) == 0, 1'b1);
        end
        rst_ni = 1'b0;
        flush_valid_i = 1'b0;
        in_valid_i = 1'b0;
        in_req_i = '0;
        write_valid_i = 1'b0;
        write_i = '0;
        out_ready_i = 1'b1;
        repeat (5) @(negedge clk_i);
        rst_ni = 1'b1;
        check_init();
        foreach (rows[n]) begin
            case (rows[n].op)
                OP_LOOKUP: begin
                    if (!rows[n].bp) drain();
                    bp_on = rows[n].bp;
                    do_lookup(rows[n]);
                    if (!rows[n].bp) drain();
                end
                OP_REFILL: begin
                    drain();
                    do_refill(rows[n]);
                end
                default: begin
                    drain();
                    flush_valid_i = 1'b1;
                    @(negedge clk_i);
                    flush_valid_i = 1'b0;
                    check_init();
                end
            endcase
        end
        drain();
        $display("*** PASSED ***");
        $finish;
    end

endmodule

//--- src.f
rtl/icache_pkg.sv
rtl/icache_sram.sv
rtl/icache_init_ctrl.sv
rtl/icache_tag_stage.sv
rtl/icache_data_stage.sv
rtl/icache_lookup.sv
sim/icache_lookup_asserts.sv
sim/tb_icache_lookup.sv
